// File: sim.f
source/cpuPkg.sv
source/alu.sv
source/regFile.sv
source/instrDecoder.sv
source/wordMemory.sv
source/controlFsm.sv
source/datapath.sv
source/cpuTop.sv
tests/cpuTop_chk.sv
tests/cpuTb.sv

// File: source/alu.sv
module alu import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,       // execute phase from datapath
    input  aluOp_t               op,
    input  logic [wordWidth-1:0] a,
    input  logic [wordWidth-1:0] b,
    output logic [wordWidth-1:0] result
);

    logic [3:0] shamt;

    assign shamt = b[3:0];   // shifts past 15 not encodable

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else if (en) begin
            case (op)
                aluAdd: result <= a + b;        // wraps mod 2^16
                aluSub: result <= a - b;
                aluOr:  result <= a | b;
                aluAnd: result <= a & b;
                aluXor: result <= a ^ b;
                aluSl:  result <= a << shamt;  // logical
                aluSr:  result <= a >> shamt;
                // unsigned compares, zero-extended flag
                aluGt:  result <= {{(wordWidth-1){1'b0}}, (a > b)};
                aluLt:  result <= {{(wordWidth-1){1'b0}}, (a < b)};
                aluEq:  result <= {{(wordWidth-1){1'b0}}, (a == b)};
                default: result <= result;     // idle holds
            endcase
        end
    end

endmodule

// File: source/controlFsm.sv
module controlFsm import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  instrClass_t instrClass,   // decoded from the IR
    output ctrl_t       ctrl
);

    state_t state;
    state_t nextState;

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    always_comb begin
        nextState = stFetch;   // last state of every path
        case (state)
            stFetch:   nextState = stDecode;
            stDecode: begin
                // IR is valid here, branch on class
                case (instrClass)
                    classAlu:   nextState = stExecute;
                    classLoad:  nextState = stMemRead;
                    classStore: nextState = stStore;
                    default:    nextState = stFetch;   // BR, unused opcodes
                endcase
            end
            stExecute: nextState = stAluWrite;
            stMemRead: nextState = stLoadWrite;
            default:   nextState = stFetch;
        endcase
    end

    // enables decoded from state alone
    always_comb begin
        ctrl = '0;
        case (state)
            stFetch: begin
                ctrl.pcEn = 1'b1;        // PC+1 and IR load together
                ctrl.irEn = 1'b1;
            end
            stMemRead: begin
                ctrl.mdrEn       = 1'b1;
                ctrl.addrFromReg = 1'b1; // address from rA
            end
            stAluWrite: begin
                ctrl.rfWrite = 1'b1;
            end
            stLoadWrite: begin
                ctrl.rfWrite   = 1'b1;
                ctrl.wbFromMdr = 1'b1;
            end
            stStore: begin
                ctrl.memWrite    = 1'b1;
                ctrl.addrFromReg = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int wordWidth    = 16;   // data and address word
    localparam int regCount     = 8;
    localparam int regIdxWidth  = 3;
    localparam int memDepth     = 256;  // code and data share it
    localparam int memAddrWidth = 8;    // low address bits only
    localparam int immWidth     = 5;    // sign-extended in datapath

    ////////////////////////////////////////////////////////////
    // opcodes, bits 4:0 of the instruction
    ////////////////////////////////////////////////////////////

    localparam logic [4:0] opAdd  = 5'd0;
    localparam logic [4:0] opSub  = 5'd1;
    localparam logic [4:0] opOr   = 5'd2;
    localparam logic [4:0] opAnd  = 5'd3;
    localparam logic [4:0] opXor  = 5'd4;
    localparam logic [4:0] opSl   = 5'd5;
    localparam logic [4:0] opSr   = 5'd6;
    localparam logic [4:0] opAddi = 5'd7;   // immediate forms 7..13
    localparam logic [4:0] opSubi = 5'd8;
    localparam logic [4:0] opOri  = 5'd9;
    localparam logic [4:0] opAndi = 5'd10;
    localparam logic [4:0] opXori = 5'd11;
    localparam logic [4:0] opSli  = 5'd12;
    localparam logic [4:0] opSri  = 5'd13;
    localparam logic [4:0] opGt   = 5'd14;  // unsigned compares
    localparam logic [4:0] opLt   = 5'd15;
    localparam logic [4:0] opEq   = 5'd16;
    localparam logic [4:0] opBr   = 5'd17;  // decoded as a no-op
    localparam logic [4:0] opStw  = 5'd18;
    localparam logic [4:0] opLdw  = 5'd19;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        aluIdle, aluAdd, aluSub, aluOr, aluAnd, aluXor,
        aluSl, aluSr, aluGt, aluLt, aluEq
    } aluOp_t;

    typedef enum logic [1:0] {
        classAlu, classLoad, classStore, classNone
    } instrClass_t;

    typedef enum logic [2:0] {
        stFetch, stDecode, stExecute, stAluWrite,
        stMemRead, stLoadWrite, stStore
    } state_t;

    // one IR word, read as register form or immediate form
    typedef union packed {
        struct packed {
            logic [regIdxWidth-1:0] rOut;
            logic [regIdxWidth-1:0] rA;
            logic [regIdxWidth-1:0] rB;
            logic [1:0]             unused;
            logic [4:0]             opcode;
        } regForm;
        struct packed {
            logic [regIdxWidth-1:0] rOut;
            logic [regIdxWidth-1:0] rA;
            logic [immWidth-1:0]    imm;
            logic [4:0]             opcode;
        } immForm;
    } instrWord_u;

    typedef struct packed {
        logic pcEn;
        logic irEn;
        logic mdrEn;
        logic memWrite;
        logic rfWrite;
        logic addrFromReg;  // address from rA instead of PC
        logic wbFromMdr;    // writeback from MDR instead of ALU
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [regIdxWidth-1:0] regIdx;
        logic [wordWidth-1:0]   data;
    } wbReport_t;

    typedef struct packed {
        logic                 valid;
        logic [wordWidth-1:0] addr;
        logic [wordWidth-1:0] data;
    } storeReport_t;

    typedef struct packed {
        logic                    en;
        logic [memAddrWidth-1:0] addr;
        logic [wordWidth-1:0]    data;
    } loadPort_t;

endpackage

// File: source/cpuTop.sv
module cpuTop import cpuPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  loadPort_t    load,   // preload, only while in reset
    output wbReport_t    wb,
    output storeReport_t store
);

    ctrl_t                ctrl;
    instrClass_t          instrClass;
    logic [wordWidth-1:0] memAddr;
    logic [wordWidth-1:0] memWdata;
    logic [wordWidth-1:0] memRdata;
    logic                 memWe;

    controlFsm iFsm (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .ctrl       (ctrl)
    );

    datapath iDatapath (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .memRdata   (memRdata),
        .instrClass (instrClass),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .memWe      (memWe),
        .wb         (wb),
        .store      (store)
    );

    wordMemory iMemory (
        .clk   (clk),
        .load  (load),
        .addr  (memAddr),
        .wdata (memWdata),
        .we    (memWe),
        .rdata (memRdata)
    );

endmodule

// File: source/datapath.sv
module datapath import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrl_t                ctrl,
    input  logic [wordWidth-1:0] memRdata,
    output instrClass_t          instrClass,
    output logic [wordWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWdata,
    output logic                 memWe,
    output wbReport_t            wb,
    output storeReport_t         store
);

    logic [wordWidth-1:0] pc;
    instrWord_u           ir;
    logic [wordWidth-1:0] mdr;     // load data

    aluOp_t               aluOp;
    logic                 immSel;
    logic                 aluEn;
    logic [wordWidth-1:0] immExt;
    logic [wordWidth-1:0] operandB;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] rdDataA;
    logic [wordWidth-1:0] rdDataB;
    logic [wordWidth-1:0] wbData;

    ////////////////////////////////////////////////////////////
    // PC, IR, MDR
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc  <= '0;
            ir  <= '0;
            mdr <= '0;
        end else begin
            if (ctrl.pcEn) pc <= pc + 1'b1;
            if (ctrl.irEn) ir <= memRdata;    // fetch word
            if (ctrl.mdrEn) mdr <= memRdata;  // LDW word
        end
    end

    instrDecoder iDecoder (
        .instr      (ir),
        .aluOp      (aluOp),
        .immSel     (immSel),
        .instrClass (instrClass)
    );

    regFile iRegFile (
        .clk     (clk),
        .reset   (reset),
        .we      (ctrl.rfWrite),
        .rdIdxA  (ir.regForm.rA),
        .rdIdxB  (ir.regForm.rB),
        .wrIdx   (ir.regForm.rOut),
        .wrData  (wbData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    // sign-extend bits 9:5
    assign immExt   = {{(wordWidth-immWidth){ir.immForm.imm[immWidth-1]}}, ir.immForm.imm};
    assign operandB = immSel ? immExt : rdDataB;

    // decode and execute phases, i.e. no fetch, no writeback, no memory access
    assign aluEn = !(ctrl.irEn || ctrl.rfWrite || ctrl.addrFromReg);

    alu iAlu (
        .clk    (clk),
        .reset  (reset),
        .en     (aluEn),
        .op     (aluOp),
        .a      (rdDataA),
        .b      (operandB),
        .result (aluResult)
    );

    ////////////////////////////////////////////////////////////
    // memory side and reports
    ////////////////////////////////////////////////////////////

    assign memAddr  = ctrl.addrFromReg ? rdDataA : pc;
    assign memWdata = rdDataB;            // STW data from rB
    assign memWe    = ctrl.memWrite;

    assign wbData = ctrl.wbFromMdr ? mdr : aluResult;

    assign wb.valid    = ctrl.rfWrite;    // one-cycle pulse
    assign wb.regIdx   = ir.regForm.rOut;
    assign wb.data     = wbData;

    assign store.valid = ctrl.memWrite;
    assign store.addr  = memAddr;
    assign store.data  = memWdata;

endmodule

// File: source/instrDecoder.sv
module instrDecoder import cpuPkg::*; (
    input  instrWord_u  instr,
    output aluOp_t      aluOp,
    output logic        immSel,       // operand B from immediate
    output instrClass_t instrClass
);

    logic [4:0] opcode;

    assign opcode = instr.regForm.opcode;   // same bits in both views

    always_comb begin
        aluOp      = aluIdle;
        immSel     = 1'b0;
        instrClass = classAlu;
        case (opcode)
            // register forms
            opAdd:  aluOp = aluAdd;
            opSub:  aluOp = aluSub;
            opOr:   aluOp = aluOr;
            opAnd:  aluOp = aluAnd;
            opXor:  aluOp = aluXor;
            opSl:   aluOp = aluSl;
            opSr:   aluOp = aluSr;
            // immediate forms
            opAddi: aluOp = aluAdd;
            opSubi: aluOp = aluSub;
            opOri:  aluOp = aluOr;
            opAndi: aluOp = aluAnd;
            opXori: aluOp = aluXor;
            opSli:  aluOp = aluSl;
            opSri:  aluOp = aluSr;
            // compares, 1 or 0
            opGt:   aluOp = aluGt;
            opLt:   aluOp = aluLt;
            opEq:   aluOp = aluEq;
            // memory
            opStw:  instrClass = classStore;
            opLdw:  instrClass = classLoad;
            opBr:   instrClass = classNone;   // branch not supported
            default: begin
                instrClass = classNone;       // opcodes 20..31
            end
        endcase

        // 7..13 take the 5-bit immediate
        if (opcode >= opAddi && opcode <= opSri) begin
            immSel = 1'b1;
        end
    end

endmodule

// File: source/regFile.sv
module regFile import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we,
    input  logic [regIdxWidth-1:0] rdIdxA,
    input  logic [regIdxWidth-1:0] rdIdxB,
    input  logic [regIdxWidth-1:0] wrIdx,
    input  logic [wordWidth-1:0]   wrData,
    output logic [wordWidth-1:0]   rdDataA,
    output logic [wordWidth-1:0]   rdDataB
);

    logic [wordWidth-1:0] regs [regCount];   // r0 is writable too

    // one write port
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wrIdx] <= wrData;
        end
    end

    // reads see the old value in a write cycle
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

endmodule

// File: source/wordMemory.sv
module wordMemory import cpuPkg::*; (
    input  logic                 clk,
    input  loadPort_t            load,    // program preload
    input  logic [wordWidth-1:0] addr,
    input  logic [wordWidth-1:0] wdata,
    input  logic                 we,
    output logic [wordWidth-1:0] rdata
);

    logic [wordWidth-1:0]    mem [memDepth];
    logic [memAddrWidth-1:0] wordAddr;

    assign wordAddr = addr[memAddrWidth-1:0];   // upper bits ignored

    // single write port, preload wins
    always_ff @(posedge clk) begin
        if (load.en) begin
            mem[load.addr] <= load.data;
        end else if (we) begin
            mem[wordAddr] <= wdata;
        end
    end

    // async read, feeds IR and MDR
    assign rdata = mem[wordAddr];

endmodule

// File: tests/cpuTb.sv
module cpuTb import cpuPkg::*; ();

    localparam int resetHold     = 8;    // reset cycles after the preload
    localparam int reportTimeout = 40;   // longest legal gap is far shorter

    logic         clk = 1'b0;
    logic         reset;
    loadPort_t    load;
    wbReport_t    wb;
    storeReport_t store;

    int          seed = 41880;
    int          pending;                // cycles since the last report
    logic [15:0] prog [$];
    logic [15:0] model [regCount];       // expected register contents
    logic [15:0] modelMem [memDepth];
    int          expKinds [$];           // 1 writeback, 2 store
    logic [15:0] expAddrs [$];           // register index or memory address
    logic [15:0] expDatas [$];
    int          expGaps [$];            // cycles from previous report or release

    always #10 clk = ~clk;

    cpuTop i_dut (.clk(clk), .reset(reset), .load(load), .wb(wb), .store(store));

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            abortRun();
        end
    endtask

    task automatic expectNoReport();
        checkValue("wb.valid", wb.valid, 1'b0);
        checkValue("store.valid", store.valid, 1'b0);
    endtask

    // counts falling edges up to the next report
    task automatic waitReport(output int cycles);
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (wb.valid || store.valid) begin
                seen = 1'b1;
            end else if (cycles >= reportTimeout) begin
                $display("timeout: no report from the CPU within %0d cycles", reportTimeout);
                abortRun();
            end
        end
    endtask

    task automatic checkReports();
        int          gap;
        int          kind;
        logic [15:0] expA;
        logic [15:0] expD;
        while (expKinds.size() > 0) begin
            kind = expKinds.pop_front();
            expA = expAddrs.pop_front();
            expD = expDatas.pop_front();
            waitReport(gap);
            checkValue("report gap in cycles", gap, expGaps.pop_front());
            checkValue("wb.valid", wb.valid, kind == 1);
            checkValue("store.valid", store.valid, kind == 2);
            if (kind == 1) begin
                checkValue("wb.regIdx", wb.regIdx, expA);
                checkValue("wb.data", wb.data, expD);
            end else begin
                checkValue("store.addr", store.addr, expA);
                checkValue("store.data", store.data, expD);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model and program builder
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] aluModel(input logic [4:0] op, input logic [15:0] a,
                                             input logic [15:0] b);
        case (op)
            opAdd, opAddi: return a + b;
            opSub, opSubi: return a - b;
            opOr,  opOri:  return a | b;
            opAnd, opAndi: return a & b;
            opXor, opXori: return a ^ b;
            opSl,  opSli:  return a << b[3:0];
            opSr,  opSri:  return a >> b[3:0];
            opGt:          return (a > b) ? 16'd1 : 16'd0;
            opLt:          return (a < b) ? 16'd1 : 16'd0;
            opEq:          return (a == b) ? 16'd1 : 16'd0;
            default:       return 16'd0;
        endcase
    endfunction

    // unused opcodes 20..31, upper byte is the address
    function automatic logic [15:0] fillWord(input int a);
        logic [4:0] op;
        op = 5'(20 + (a % 12));
        return {a[7:0], 3'b000, op};
    endfunction

    task automatic newProgram();
        prog.delete();
        foreach (model[i]) model[i] = '0;   // reset clears every register
        pending = 0;
    endtask

    task automatic pushWord(input logic [15:0] word, input int cycles);
        prog.push_back(word);
        pending += cycles;
    endtask

    task automatic expectReport(input int kind, input logic [15:0] a, input logic [15:0] d);
        expKinds.push_back(kind);
        expAddrs.push_back(a);
        expDatas.push_back(d);
        expGaps.push_back(pending);   // pulse sits in the last cycle
        pending = 0;
    endtask

    // src is rB for register forms, the immediate for 7..13
    task automatic emitAlu(input logic [4:0] op, input int rd, input int ra, input int src);
        logic [15:0] b;
        logic [4:0]  imm;
        imm = src[4:0];
        if (op >= opAddi && op <= opSri) begin
            b = {{11{imm[4]}}, imm};
            pushWord({rd[2:0], ra[2:0], imm, op}, 4);
        end else begin
            b = model[src];
            pushWord({rd[2:0], ra[2:0], src[2:0], 2'b00, op}, 4);
        end
        model[rd] = aluModel(op, model[ra], b);
        expectReport(1, rd, model[rd]);
    endtask

    task automatic emitStore(input int ra, input int rb);
        pushWord({3'b000, ra[2:0], rb[2:0], 2'b00, opStw}, 3);
        modelMem[model[ra][7:0]] = model[rb];
        expectReport(2, model[ra], model[rb]);
    endtask

    task automatic emitLoad(input int rd, input int ra);
        pushWord({rd[2:0], ra[2:0], 3'b000, 2'b00, opLdw}, 4);
        model[rd] = modelMem[model[ra][7:0]];
        expectReport(1, rd, model[rd]);
    endtask

    // a nibble at a time, starting with ADDI from r0
    task automatic setReg(input int rd, input logic [15:0] value);
        emitAlu(opAddi, rd, 0, value[15:12]);
        for (int n = 2; n >= 0; n--) begin
            emitAlu(opSli, rd, rd, 4);
            emitAlu(opOri, rd, rd, (value >> (4 * n)) & 16'hf);
        end
    endtask

    // whole memory written while reset is held, then release
    task automatic loadProgram();
        logic [15:0] word;
        for (int a = 0; a < memDepth; a++) begin
            word = (a < prog.size()) ? prog[a] : fillWord(a);
            @(posedge clk);
            reset <= 1'b1;
            load  <= '{en: 1'b1, addr: a[7:0], data: word};
            @(negedge clk);
            expectNoReport();
        end
        for (int c = 0; c < resetHold; c++) begin
            @(posedge clk);
            load <= '0;
            @(negedge clk);
            expectNoReport();
        end
        @(posedge clk);
        reset <= 1'b0;   // fetch of word 0 in the next cycle
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    // first writeback 4 cycles after release, each no-op costs 2
    task automatic testResetAndNoOps();
        logic [15:0] word;
        newProgram();
        emitAlu(opAddi, 1, 0, 3);
        word      = $random(seed);
        word[4:0] = opBr;
        pushWord(word, 2);
        emitAlu(opAddi, 2, 1, -2);
        word      = $random(seed);
        word[4:0] = 5'd25;           // unused opcode
        pushWord(word, 2);
        emitAlu(opAdd, 3, 1, 2);
        loadProgram();
        checkReports();
    endtask

    task automatic testRegisterOps();
        newProgram();
        setReg(1, $random(seed));
        setReg(2, $random(seed));
        for (int i = 0; i < 7; i++) begin
            emitAlu(5'(opAdd + i), 3 + (i % 5), 1, 2);   // add .. sr
        end
        loadProgram();
        checkReports();
    endtask

    task automatic testImmediateOps();
        int negImm;
        int posImm;
        newProgram();
        setReg(1, $random(seed));
        for (int i = 0; i < 7; i++) begin
            negImm = -16 + ($random(seed) & 15);
            posImm = $random(seed) & 15;
            emitAlu(5'(opAddi + i), 2, 1, negImm);
            emitAlu(5'(opAddi + i), 3, 1, posImm);
        end
        loadProgram();
        checkReports();
    endtask

    task automatic testCompares();
        logic [15:0] x;
        logic [15:0] y;
        x = $random(seed);
        y = $random(seed);
        if (y == x) y = x ^ 16'h0100;
        newProgram();
        setReg(1, x);
        emitAlu(opAdd, 2, 1, 0);      // r2 = r1, equal pair
        setReg(3, y);
        for (int i = 0; i < 3; i++) begin
            emitAlu(5'(opGt + i), 4, 1, 2);
            emitAlu(5'(opGt + i), 5, 1, 3);
            emitAlu(5'(opGt + i), 6, 3, 1);
        end
        loadProgram();
        checkReports();
    endtask

    task automatic testStoreLoad();
        logic [15:0] addr;
        addr    = $random(seed);
        addr[7] = 1'b1;               // data area above the program
        newProgram();
        setReg(1, addr);
        setReg(2, $random(seed));
        emitStore(1, 2);
        emitAlu(opAddi, 3, 0, 7);
        emitLoad(4, 1);
        loadProgram();
        checkReports();
    endtask

    initial begin
        reset <= 1'b1;
        load  <= '0;
        testResetAndNoOps();
        testRegisterOps();
        testImmediateOps();
        testCompares();
        testStoreLoad();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tests/cpuTop_chk.sv
module cpuTopChk import cpuPkg::*; (
    input logic         clk,
    input logic         reset,
    input wbReport_t    wb,
    input storeReport_t store
);

    ////////////////////////////////////////////////////////////
    // report strobes
    ////////////////////////////////////////////////////////////

    // a cycle writes a register or memory, never both
    notBoth: assert property (@(posedge clk) disable iff (reset)
        !(wb.valid && store.valid))
        else $error("writeback and store reported in the same cycle");

    wbPulse: assert property (@(posedge clk) disable iff (reset)
        wb.valid |=> !wb.valid)   // one write state per instruction
        else $error("wb.valid high on two consecutive cycles");

    storePulse: assert property (@(posedge clk) disable iff (reset)
        store.valid |=> !store.valid)
        else $error("store.valid high on two consecutive cycles");

    quietInReset: assert property (@(posedge clk)
        reset |-> !wb.valid && !store.valid)
        else $error("report valid while reset is held");

endmodule

bind cpuTop cpuTopChk iChk (
    .clk   (clk),
    .reset (reset),
    .wb    (wb),
    .store (store)
);
